//--- source/isa_pkg.sv
package isa_pkg;

	// ==================================================
	// Field widths of the instruction word
	// ==================================================
	localparam int OPCODE_BITS = 6;
	localparam int REG_BITS = 5;
	localparam int IMM_BITS = 14;

	typedef logic [OPCODE_BITS-1:0] opcode_t;

	// Functional-unit class, values 5 to 7 are unused
	typedef logic [2:0] op_class_t;

	localparam op_class_t CLS_ALU = 3'd0;
	localparam op_class_t CLS_ALU0 = 3'd1;
	localparam op_class_t CLS_MULDIV = 3'd2;
	localparam op_class_t CLS_BRANCH = 3'd3;
	localparam op_class_t CLS_MEM = 3'd4;

	// Opcode zero is the NOP so that a cleared word decodes harmlessly
	localparam opcode_t OP_NOP = 6'h00;
	localparam opcode_t OP_ADD = 6'h01;
	localparam opcode_t OP_SUB = 6'h02;
	localparam opcode_t OP_ADDI = 6'h03;
	// Shifts only exist on the first ALU
	localparam opcode_t OP_SHL = 6'h04;
	localparam opcode_t OP_SHLI = 6'h05;
	localparam opcode_t OP_MUL = 6'h08;
	localparam opcode_t OP_DIV = 6'h09;
	localparam opcode_t OP_BEQ = 6'h10;
	localparam opcode_t OP_LD = 6'h18;
	localparam opcode_t OP_ST = 6'h19;

	// Both forms share opcode, rd and rs1 in the upper bits
	// The low 16 bits hold either rs2 plus a function field or an immediate
	typedef union packed {
		struct packed {
			opcode_t opcode;
			logic [REG_BITS-1:0] rd;
			logic [REG_BITS-1:0] rs1;
			logic [REG_BITS-1:0] rs2;
			logic [10:0] funct;
		} r;
		struct packed {
			opcode_t opcode;
			logic [REG_BITS-1:0] rd;
			logic [REG_BITS-1:0] rs1;
			logic [1:0] rsvd;
			logic [IMM_BITS-1:0] imm;
		} i;
	} instr_word_t;

	// Returns the class of an opcode and whether it uses the immediate form
	function automatic op_class_t op_class_of(input opcode_t op, output logic is_imm);
		op_class_t cls;
		cls = CLS_ALU;
		is_imm = 1'b0;
		case (op)
			OP_NOP, OP_ADD, OP_SUB: cls = CLS_ALU;
			OP_ADDI: is_imm = 1'b1;
			OP_SHL: cls = CLS_ALU0;
			OP_SHLI: begin
				cls = CLS_ALU0;
				is_imm = 1'b1;
			end
			OP_MUL, OP_DIV: cls = CLS_MULDIV;
			// Branch offset sits in the immediate
			OP_BEQ: begin
				cls = CLS_BRANCH;
				is_imm = 1'b1;
			end
			OP_LD, OP_ST: begin
				cls = CLS_MEM;
				is_imm = 1'b1;
			end
			default: cls = CLS_ALU;
		endcase
		return cls;
	endfunction

endpackage

//--- source/dispatch_pkg.sv
package dispatch_pkg;

	// ==================================================
	// Dispatch slots
	// ==================================================
	localparam int SLOT_COUNT = 5;

	// Slot numbering, two ALUs followed by one slot per remaining class
	localparam int SLOT_ALU0 = 0;
	localparam int SLOT_ALU1 = 1;
	localparam int SLOT_MULDIV = 2;
	localparam int SLOT_BRANCH = 3;
	localparam int SLOT_MEM = 4;

	// ==================================================
	// Tags and operands
	// ==================================================
	localparam int PREG_BITS = 7;

	// Second operand is wide enough for a sign-extended 14 bit immediate
	localparam int OPERAND_BITS = 16;

	typedef logic [PREG_BITS-1:0] preg_t;

	// One reorder-buffer entry, 58 bits
	// valid and dispatched are the only fields cleared by reset
	typedef struct packed {
		logic valid;
		logic dispatched;
		isa_pkg::instr_word_t instr;
		preg_t psrc1;
		logic src1_ready;
		preg_t psrc2;
		// Ignored for immediate-form instructions
		logic src2_ready;
		preg_t pdst;
		// Set when the entry is squashed, it still flows through as a NOP
		logic stomp;
	} rob_entry_t;

endpackage

//--- source/rob_store.sv
`timescale 1ns/1ps

module rob_store #(
	parameter int ROB_ENTRIES = 8,
	localparam int IDX_BITS = $clog2(ROB_ENTRIES)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic alloc_v,
	input  isa_pkg::instr_word_t alloc_instr,
	input  dispatch_pkg::preg_t alloc_psrc1,
	input  dispatch_pkg::preg_t alloc_psrc2,
	input  dispatch_pkg::preg_t alloc_pdst,
	input  logic [1:0] alloc_src_ready,
	input  logic wakeup_v,
	input  dispatch_pkg::preg_t wakeup_tag,
	input  logic [ROB_ENTRIES-1:0] stomp_mask,
	input  logic commit_v,
	input  logic [ROB_ENTRIES-1:0] dispatched_mask,
	output logic alloc_ready,
	output dispatch_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_entries
);

	dispatch_pkg::rob_entry_t [ROB_ENTRIES-1:0] entries;
	dispatch_pkg::rob_entry_t new_entry;
	logic [IDX_BITS-1:0] head;
	logic [IDX_BITS-1:0] tail;
	logic [IDX_BITS:0] count;
	logic do_alloc;
	logic do_commit;

	// Pointer increment with wrap, ROB_ENTRIES need not be a power of two
	function automatic logic [IDX_BITS-1:0] next_idx(input logic [IDX_BITS-1:0] idx);
		return (idx == IDX_BITS'(ROB_ENTRIES - 1)) ? '0 : idx + 1'b1;
	endfunction

	assign alloc_ready = (count != (IDX_BITS+1)'(ROB_ENTRIES));
	assign do_alloc = alloc_v && alloc_ready;
	// Only a dispatched head may retire
	assign do_commit = commit_v && entries[head].valid && entries[head].dispatched;
	assign rob_entries = entries;

	// Build the entry written at the tail
	// A wakeup in the allocation cycle is folded into the ready bits here
	always_comb begin
		new_entry = '0;
		new_entry.valid = 1'b1;
		new_entry.instr = alloc_instr;
		new_entry.psrc1 = alloc_psrc1;
		new_entry.psrc2 = alloc_psrc2;
		new_entry.pdst = alloc_pdst;
		new_entry.src1_ready = alloc_src_ready[0] || (wakeup_v && alloc_psrc1 == wakeup_tag);
		new_entry.src2_ready = alloc_src_ready[1] || (wakeup_v && alloc_psrc2 == wakeup_tag);
	end

	// ==================================================
	// Entry state and pointers
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				entries[i].valid <= 1'b0;
				entries[i].dispatched <= 1'b0;
			end
		end else begin
			for (int i = 0; i < ROB_ENTRIES; i++) begin
				if (entries[i].valid) begin
					// Tag broadcast from a completing producer
					if (wakeup_v && entries[i].psrc1 == wakeup_tag)
						entries[i].src1_ready <= 1'b1;
					if (wakeup_v && entries[i].psrc2 == wakeup_tag)
						entries[i].src2_ready <= 1'b1;
					if (stomp_mask[i])
						entries[i].stomp <= 1'b1;
					// Flag lands one cycle after the dispatcher picked the entry
					if (dispatched_mask[i])
						entries[i].dispatched <= 1'b1;
				end
			end
			if (do_commit) begin
				entries[head].valid <= 1'b0;
				head <= next_idx(head);
			end
			// Tail slot is free whenever alloc_ready is high, so no clash with commit
			if (do_alloc) begin
				entries[tail] <= new_entry;
				tail <= next_idx(tail);
			end
			count <= count + (IDX_BITS+1)'(do_alloc) - (IDX_BITS+1)'(do_commit);
		end
	end

	// Upstream must hold off while the buffer is full
	alloc_when_full: assert property (@(posedge clk) disable iff (!rst_n)
		alloc_v |-> alloc_ready)
		else $error("rob_store: alloc_v while reorder buffer full");

	// Retirement has to wait until the dispatcher has sent the head out
	commit_undispatched: assert property (@(posedge clk) disable iff (!rst_n)
		commit_v |-> (entries[head].valid && entries[head].dispatched))
		else $error("rob_store: commit of an undispatched head entry");

endmodule

//--- source/instr_dispatcher.sv
`timescale 1ns/1ps

module instr_dispatcher #(
	parameter int ROB_ENTRIES = 8,
	localparam int IDX_BITS = $clog2(ROB_ENTRIES)
) (
	input  logic clk,
	input  logic rst_n,
	input  dispatch_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_entries,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] slot_has_credit,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] slot_enable,
	output logic [ROB_ENTRIES-1:0] dispatched_mask,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] issue_v,
	output logic [dispatch_pkg::SLOT_COUNT-1:0][IDX_BITS-1:0] issue_rob_idx,
	output isa_pkg::opcode_t [dispatch_pkg::SLOT_COUNT-1:0] issue_opcode,
	output dispatch_pkg::preg_t [dispatch_pkg::SLOT_COUNT-1:0] issue_pdst,
	output dispatch_pkg::preg_t [dispatch_pkg::SLOT_COUNT-1:0] issue_psrc1,
	output logic [dispatch_pkg::SLOT_COUNT-1:0][dispatch_pkg::OPERAND_BITS-1:0] issue_operand2,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] issue_is_imm
);

	localparam int NSLOT = dispatch_pkg::SLOT_COUNT;
	localparam int OPW = dispatch_pkg::OPERAND_BITS;

	// Selection for the next edge
	logic [NSLOT-1:0] sel_v;
	logic [NSLOT-1:0][IDX_BITS-1:0] sel_idx;
	isa_pkg::opcode_t [NSLOT-1:0] sel_opcode;
	dispatch_pkg::preg_t [NSLOT-1:0] sel_pdst;
	dispatch_pkg::preg_t [NSLOT-1:0] sel_psrc1;
	logic [NSLOT-1:0][OPW-1:0] sel_operand2;
	logic [NSLOT-1:0] sel_is_imm;
	logic [ROB_ENTRIES-1:0] sel_mask;

	// ==================================================
	// Slot selection
	// ==================================================
	// Entries are scanned from index 0 upward so the lowest index wins a slot
	always_comb begin
		isa_pkg::instr_word_t iw;
		isa_pkg::op_class_t cls;
		logic is_imm;
		logic eligible;
		logic [NSLOT-1:0] free;
		int slot;
		sel_v = '0;
		sel_idx = '0;
		sel_opcode = '0;
		sel_pdst = '0;
		sel_psrc1 = '0;
		sel_operand2 = '0;
		sel_is_imm = '0;
		sel_mask = '0;
		for (int i = 0; i < ROB_ENTRIES; i++) begin
			iw = rob_entries[i].instr;
			cls = isa_pkg::op_class_of(iw.r.opcode, is_imm);
			// Skip last cycle's picks, their dispatched flag is still in flight
			// A stomped entry goes out regardless of its sources
			eligible = rob_entries[i].valid && !rob_entries[i].dispatched &&
				!dispatched_mask[i] && (rob_entries[i].stomp ||
				(rob_entries[i].src1_ready && (is_imm || rob_entries[i].src2_ready)));
			free = slot_enable & slot_has_credit & ~sel_v;
			slot = -1;
			case (cls)
				isa_pkg::CLS_ALU: begin
					// Plain ALU ops fill slot 0 first and spill into slot 1
					if (free[dispatch_pkg::SLOT_ALU0])
						slot = dispatch_pkg::SLOT_ALU0;
					else if (free[dispatch_pkg::SLOT_ALU1])
						slot = dispatch_pkg::SLOT_ALU1;
				end
				isa_pkg::CLS_ALU0: begin
					if (free[dispatch_pkg::SLOT_ALU0])
						slot = dispatch_pkg::SLOT_ALU0;
				end
				isa_pkg::CLS_MULDIV: begin
					if (free[dispatch_pkg::SLOT_MULDIV])
						slot = dispatch_pkg::SLOT_MULDIV;
				end
				isa_pkg::CLS_BRANCH: begin
					if (free[dispatch_pkg::SLOT_BRANCH])
						slot = dispatch_pkg::SLOT_BRANCH;
				end
				isa_pkg::CLS_MEM: begin
					if (free[dispatch_pkg::SLOT_MEM])
						slot = dispatch_pkg::SLOT_MEM;
				end
				default: slot = -1;
			endcase
			if (eligible && slot >= 0) begin
				sel_v[slot] = 1'b1;
				sel_mask[i] = 1'b1;
				sel_idx[slot] = IDX_BITS'(i);
				sel_pdst[slot] = rob_entries[i].pdst;
				if (rob_entries[i].stomp) begin
					// Squashed work becomes a NOP with no source dependence
					sel_opcode[slot] = isa_pkg::OP_NOP;
					sel_psrc1[slot] = '0;
					sel_operand2[slot] = '0;
					sel_is_imm[slot] = 1'b0;
				end else begin
					sel_opcode[slot] = iw.r.opcode;
					sel_psrc1[slot] = rob_entries[i].psrc1;
					sel_is_imm[slot] = is_imm;
					// Operand two is the immediate form or the register form of the word
					if (is_imm)
						sel_operand2[slot] = {{(OPW - isa_pkg::IMM_BITS){iw.i.imm[isa_pkg::IMM_BITS-1]}},
							iw.i.imm};
					else
						sel_operand2[slot] = {{(OPW - dispatch_pkg::PREG_BITS){1'b0}},
							rob_entries[i].psrc2};
				end
			end
		end
	end

	// ==================================================
	// Issue registers
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issue_v <= '0;
			dispatched_mask <= '0;
		end else begin
			issue_v <= sel_v;
			dispatched_mask <= sel_mask;
		end
	end

	// Payload only matters where issue_v is set
	always_ff @(posedge clk) begin
		issue_rob_idx <= sel_idx;
		issue_opcode <= sel_opcode;
		issue_pdst <= sel_pdst;
		issue_psrc1 <= sel_psrc1;
		issue_operand2 <= sel_operand2;
		issue_is_imm <= sel_is_imm;
	end

	// An entry may occupy at most one slot in a given cycle
	for (genvar a = 0; a < NSLOT; a++) begin : g_slot_a
		for (genvar b = a + 1; b < NSLOT; b++) begin : g_slot_b
			one_slot_per_entry: assert property (@(posedge clk) disable iff (!rst_n)
				!(issue_v[a] && issue_v[b] && issue_rob_idx[a] == issue_rob_idx[b]))
				else $error("instr_dispatcher: entry issued on slots %0d and %0d", a, b);
		end
	end

endmodule

//--- source/slot_credit_counter.sv
`timescale 1ns/1ps

module slot_credit_counter #(
	parameter int RS_DEPTH = 4,
	localparam int CNT_BITS = $clog2(RS_DEPTH + 1)
) (
	input  logic clk,
	input  logic rst_n,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] spend,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] credit_return,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] slot_has_credit
);

	// Free reservation-station entries per slot
	logic [dispatch_pkg::SLOT_COUNT-1:0][CNT_BITS-1:0] count;

	// ==================================================
	// Counters
	// ==================================================
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s < dispatch_pkg::SLOT_COUNT; s++)
				count[s] <= CNT_BITS'(RS_DEPTH);
		end else begin
			for (int s = 0; s < dispatch_pkg::SLOT_COUNT; s++) begin
				// Spend and return together cancel out
				case ({spend[s], credit_return[s]})
					2'b10: count[s] <= count[s] - 1'b1;
					2'b01: count[s] <= count[s] + 1'b1;
					default: count[s] <= count[s];
				endcase
			end
		end
	end

	// spend is the registered issue, so the counter trails the dispatcher by a cycle
	// Subtracting the pending spend keeps the last credit from being handed out twice
	always_comb begin
		for (int s = 0; s < dispatch_pkg::SLOT_COUNT; s++)
			slot_has_credit[s] = (count[s] > CNT_BITS'(spend[s]));
	end

	for (genvar s = 0; s < dispatch_pkg::SLOT_COUNT; s++) begin : g_check
		credit_underflow: assert property (@(posedge clk) disable iff (!rst_n)
			(spend[s] && !credit_return[s]) |-> (count[s] != '0))
			else $error("slot_credit_counter: slot %0d issued without credit", s);
		// More returns than issues means the reservation station miscounted
		credit_overflow: assert property (@(posedge clk) disable iff (!rst_n)
			(credit_return[s] && !spend[s]) |-> (count[s] != CNT_BITS'(RS_DEPTH)))
			else $error("slot_credit_counter: slot %0d credit above RS_DEPTH", s);
	end

endmodule

//--- source/dispatch_config.sv
`timescale 1ns/1ps

module dispatch_config (
	input  logic clk,
	input  logic rst_n,
	input  logic cfg_we,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] cfg_wdata,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] cfg_rdata,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] slot_enable
);

	// One enable bit per dispatch slot
	logic [dispatch_pkg::SLOT_COUNT-1:0] enable_q;

	// All slots come up enabled
	always_ff @(posedge clk) begin
		if (!rst_n)
			enable_q <= {dispatch_pkg::SLOT_COUNT{1'b1}};
		else if (cfg_we)
			enable_q <= cfg_wdata;
	end

	// Read-back is the live mask, no separate shadow
	assign cfg_rdata = enable_q;
	assign slot_enable = enable_q;

	// Turning off a whole class is fine, and alu 1 can go alone
	// Disabling only alu 0 would strand alu0-only ops while plain alu ops keep flowing
	alu0_only_stranded: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_we |=> (slot_enable[dispatch_pkg::SLOT_ALU1] |-> slot_enable[dispatch_pkg::SLOT_ALU0]))
		else $error("dispatch_config: alu 0 disabled while alu 1 stays enabled");

endmodule

//--- source/dispatch_top.sv
`timescale 1ns/1ps

module dispatch_top #(
	parameter int ROB_ENTRIES = 8,
	parameter int RS_DEPTH = 4,
	localparam int IDX_BITS = $clog2(ROB_ENTRIES)
) (
	input  logic clk,
	input  logic rst_n,
	// Allocation from decode
	input  logic alloc_v,
	input  isa_pkg::instr_word_t alloc_instr,
	input  dispatch_pkg::preg_t alloc_psrc1,
	input  dispatch_pkg::preg_t alloc_psrc2,
	input  dispatch_pkg::preg_t alloc_pdst,
	input  logic [1:0] alloc_src_ready,
	output logic alloc_ready,
	// Wakeup, stomp and commit
	input  logic wakeup_v,
	input  dispatch_pkg::preg_t wakeup_tag,
	input  logic [ROB_ENTRIES-1:0] stomp_mask,
	input  logic commit_v,
	// Credits back from the reservation stations
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] credit_return,
	// Configuration access
	input  logic cfg_we,
	input  logic [dispatch_pkg::SLOT_COUNT-1:0] cfg_wdata,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] cfg_rdata,
	// Issue slots
	output logic [dispatch_pkg::SLOT_COUNT-1:0] issue_v,
	output logic [dispatch_pkg::SLOT_COUNT-1:0][IDX_BITS-1:0] issue_rob_idx,
	output isa_pkg::opcode_t [dispatch_pkg::SLOT_COUNT-1:0] issue_opcode,
	output dispatch_pkg::preg_t [dispatch_pkg::SLOT_COUNT-1:0] issue_pdst,
	output dispatch_pkg::preg_t [dispatch_pkg::SLOT_COUNT-1:0] issue_psrc1,
	output logic [dispatch_pkg::SLOT_COUNT-1:0][dispatch_pkg::OPERAND_BITS-1:0] issue_operand2,
	output logic [dispatch_pkg::SLOT_COUNT-1:0] issue_is_imm
);

	dispatch_pkg::rob_entry_t [ROB_ENTRIES-1:0] rob_entries;
	logic [ROB_ENTRIES-1:0] dispatched_mask;
	logic [dispatch_pkg::SLOT_COUNT-1:0] slot_has_credit;
	logic [dispatch_pkg::SLOT_COUNT-1:0] slot_enable;

	rob_store #(.ROB_ENTRIES(ROB_ENTRIES)) u_rob (
		.clk(clk), .rst_n(rst_n),
		.alloc_v(alloc_v), .alloc_instr(alloc_instr),
		.alloc_psrc1(alloc_psrc1), .alloc_psrc2(alloc_psrc2), .alloc_pdst(alloc_pdst),
		.alloc_src_ready(alloc_src_ready),
		.wakeup_v(wakeup_v), .wakeup_tag(wakeup_tag),
		.stomp_mask(stomp_mask), .commit_v(commit_v),
		.dispatched_mask(dispatched_mask),
		.alloc_ready(alloc_ready), .rob_entries(rob_entries)
	);

	instr_dispatcher #(.ROB_ENTRIES(ROB_ENTRIES)) u_disp (
		.clk(clk), .rst_n(rst_n),
		.rob_entries(rob_entries),
		.slot_has_credit(slot_has_credit), .slot_enable(slot_enable),
		.dispatched_mask(dispatched_mask),
		.issue_v(issue_v), .issue_rob_idx(issue_rob_idx), .issue_opcode(issue_opcode),
		.issue_pdst(issue_pdst), .issue_psrc1(issue_psrc1),
		.issue_operand2(issue_operand2), .issue_is_imm(issue_is_imm)
	);

	// Each registered issue spends one credit of its slot
	slot_credit_counter #(.RS_DEPTH(RS_DEPTH)) u_credit (
		.clk(clk), .rst_n(rst_n),
		.spend(issue_v), .credit_return(credit_return),
		.slot_has_credit(slot_has_credit)
	);

	dispatch_config u_cfg (
		.clk(clk), .rst_n(rst_n),
		.cfg_we(cfg_we), .cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata), .slot_enable(slot_enable)
	);

endmodule

//--- verification/tb_dispatch_tasks.svh
// ==================================================
// Drive and check helpers
// ==================================================
// Every drive task acts on a rising edge and returns at the following falling edge
// Outputs are sampled there, half a cycle away from any update

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		$display("Simulation finished: FAIL");
		$fatal(1, "mismatch on %s", name);
	end
endtask

// One-cycle pulses fall back to idle unless the caller sets them again
task automatic clear_pulses();
	alloc_v <= 1'b0;
	wakeup_v <= 1'b0;
	stomp_mask <= '0;
	commit_v <= 1'b0;
	cfg_we <= 1'b0;
	credit_return <= '0;
endtask

task automatic next_cycle();
	@(posedge clk);
	clear_pulses();
	@(negedge clk);
endtask

// Reset is sampled low on 16 rising edges
task automatic apply_reset();
	@(posedge clk);
	rst_n <= 1'b0;
	clear_pulses();
	repeat (RESET_CYCLES) @(posedge clk);
	rst_n <= 1'b1;
	@(negedge clk);
endtask

task automatic push_instr(input isa_pkg::instr_word_t w, input dispatch_pkg::preg_t ps1,
		input dispatch_pkg::preg_t ps2, input dispatch_pkg::preg_t pd, input logic [1:0] rdy);
	@(posedge clk);
	clear_pulses();
	alloc_v <= 1'b1;
	alloc_instr <= w;
	alloc_psrc1 <= ps1;
	alloc_psrc2 <= ps2;
	alloc_pdst <= pd;
	alloc_src_ready <= rdy;
	@(negedge clk);
endtask

task automatic send_wakeup(input dispatch_pkg::preg_t tag);
	@(posedge clk);
	clear_pulses();
	wakeup_v <= 1'b1;
	wakeup_tag <= tag;
	@(negedge clk);
endtask

task automatic write_enable_mask(input logic [NSLOT-1:0] mask);
	@(posedge clk);
	clear_pulses();
	cfg_we <= 1'b1;
	cfg_wdata <= mask;
	@(negedge clk);
endtask

task automatic return_credits(input logic [NSLOT-1:0] mask);
	@(posedge clk);
	clear_pulses();
	credit_return <= mask;
	@(negedge clk);
endtask

task automatic stomp_entries(input logic [ROB_ENTRIES-1:0] mask);
	@(posedge clk);
	clear_pulses();
	stomp_mask <= mask;
	@(negedge clk);
endtask

task automatic commit_head();
	@(posedge clk);
	clear_pulses();
	commit_v <= 1'b1;
	@(negedge clk);
endtask

// Register form with random register fields
function automatic isa_pkg::instr_word_t make_r(input isa_pkg::opcode_t op);
	isa_pkg::instr_word_t w;
	w.r.opcode = op;
	w.r.rd = 5'(rand_bits(5));
	w.r.rs1 = 5'(rand_bits(5));
	w.r.rs2 = 5'(rand_bits(5));
	w.r.funct = 11'(rand_bits(11));
	return w;
endfunction

function automatic isa_pkg::instr_word_t make_i(input isa_pkg::opcode_t op,
		input logic [13:0] imm);
	isa_pkg::instr_word_t w;
	w.i.opcode = op;
	w.i.rd = 5'(rand_bits(5));
	w.i.rs1 = 5'(rand_bits(5));
	w.i.rsvd = '0;
	w.i.imm = imm;
	return w;
endfunction

task automatic expect_idle(input int n);
	repeat (n) begin
		next_cycle();
		check_val("issue_v", 32'(issue_v), 32'h0);
	end
endtask

// Advances one cycle and expects exactly the given slots to issue
task automatic expect_issue(input logic [NSLOT-1:0] mask, input int slot, input int idx);
	next_cycle();
	check_val("issue_v", 32'(issue_v), 32'(mask));
	check_val("issue_rob_idx", 32'(issue_rob_idx[slot]), idx);
endtask

// ==================================================
// Directed tests
// ==================================================
task automatic test_reset_state();
	apply_reset();
	check_val("issue_v", 32'(issue_v), 32'h0);
	check_val("alloc_ready", 32'(alloc_ready), 32'h1);
	check_val("cfg_rdata", 32'(cfg_rdata), 32'h1f);
	expect_idle(2);
endtask

task automatic test_single_issue();
	dispatch_pkg::preg_t ps1;
	dispatch_pkg::preg_t ps2;
	dispatch_pkg::preg_t pd;
	logic [13:0] imm;
	apply_reset();
	ps1 = rand_tag();
	ps2 = rand_tag();
	pd = rand_tag();
	// Both sources ready so only the two pipeline stages stand in the way
	push_instr(make_r(isa_pkg::OP_ADD), ps1, ps2, pd, 2'b11);
	expect_idle(1);
	expect_issue(5'b00001, 0, 0);
	check_val("issue_opcode", 32'(issue_opcode[0]), 32'(isa_pkg::OP_ADD));
	check_val("issue_pdst", 32'(issue_pdst[0]), 32'(pd));
	check_val("issue_psrc1", 32'(issue_psrc1[0]), 32'(ps1));
	check_val("issue_operand2", 32'(issue_operand2[0]), 32'(ps2));
	check_val("issue_is_imm", 32'(issue_is_imm[0]), 32'h0);
	// Sign bit forced on so the extension shows in the upper operand bits
	imm = 14'(rand_bits(14)) | 14'h2000;
	// The second source is left unready and must not matter for the immediate form
	push_instr(make_i(isa_pkg::OP_ADDI, imm), ps1, ps2, pd, 2'b01);
	expect_idle(1);
	expect_issue(5'b00001, 0, 1);
	check_val("issue_is_imm", 32'(issue_is_imm[0]), 32'h1);
	// A negative immediate fills the two upper operand bits with ones
	check_val("issue_operand2", 32'(issue_operand2[0]), 32'({2'b11, imm}));
endtask

task automatic test_wakeup();
	dispatch_pkg::preg_t t;
	apply_reset();
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_SUB), t, rand_tag(), rand_tag(), 2'b10);
	expect_idle(3);
	send_wakeup(t ^ 7'h5a);
	expect_idle(3);
	send_wakeup(t);
	expect_idle(1);
	expect_issue(5'b00001, 0, 0);
	check_val("issue_psrc1", 32'(issue_psrc1[0]), 32'(t));
endtask

task automatic test_class_limits();
	dispatch_pkg::preg_t t;
	apply_reset();
	// Two ALU ops held on one tag become ready in the same cycle
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	push_instr(make_r(isa_pkg::OP_SUB), t, rand_tag(), rand_tag(), 2'b10);
	send_wakeup(t);
	expect_idle(1);
	expect_issue(5'b00011, 0, 0);
	check_val("issue_rob_idx", 32'(issue_rob_idx[1]), 32'd1);
	// Only one mul/div slot exists so the pair is serialized
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_MUL), t, rand_tag(), rand_tag(), 2'b10);
	push_instr(make_r(isa_pkg::OP_DIV), t, rand_tag(), rand_tag(), 2'b10);
	send_wakeup(t);
	expect_idle(1);
	expect_issue(5'b00100, 2, 2);
	expect_issue(5'b00100, 2, 3);
	// A shift waits for slot 0 instead of taking the free slot 1
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	push_instr(make_r(isa_pkg::OP_SHL), t, rand_tag(), rand_tag(), 2'b10);
	send_wakeup(t);
	expect_idle(1);
	expect_issue(5'b00001, 0, 4);
	expect_issue(5'b00001, 0, 5);
	check_val("issue_opcode", 32'(issue_opcode[0]), 32'(isa_pkg::OP_SHL));
endtask

task automatic test_credits_config();
	dispatch_pkg::preg_t t;
	apply_reset();
	t = rand_tag();
	for (int k = 0; k < 6; k++)
		push_instr(make_r(isa_pkg::OP_MUL), t, rand_tag(), rand_tag(), 2'b10);
	send_wakeup(t);
	expect_idle(1);
	// The mul/div station holds RS_DEPTH entries and none come back yet
	for (int k = 0; k < RS_DEPTH; k++)
		expect_issue(5'b00100, 2, k);
	expect_idle(3);
	return_credits(5'b00100);
	expect_idle(1);
	expect_issue(5'b00100, 2, RS_DEPTH);
	expect_idle(2);
	// With alu 1 off the second ALU op waits a cycle for slot 0
	write_enable_mask(5'b11101);
	next_cycle();
	check_val("cfg_rdata", 32'(cfg_rdata), 32'h1d);
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	send_wakeup(t);
	expect_idle(1);
	expect_issue(5'b00001, 0, 6);
	expect_issue(5'b00001, 0, 7);
endtask

task automatic test_stomp_commit();
	dispatch_pkg::preg_t t;
	apply_reset();
	// This tag is never woken so only the stomp can release the entry
	t = rand_tag();
	push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	stomp_entries(ROB_ENTRIES'(1));
	expect_idle(1);
	expect_issue(5'b00001, 0, 0);
	check_val("issue_opcode", 32'(issue_opcode[0]), 32'(isa_pkg::OP_NOP));
	// Fill the remaining entries with work that stays blocked
	for (int k = 1; k < ROB_ENTRIES; k++)
		push_instr(make_r(isa_pkg::OP_ADD), t, rand_tag(), rand_tag(), 2'b10);
	expect_idle(1);
	check_val("alloc_ready", 32'(alloc_ready), 32'h0);
	// The stomped head has dispatched and may retire
	commit_head();
	check_val("alloc_ready", 32'(alloc_ready), 32'h0);
	next_cycle();
	check_val("alloc_ready", 32'(alloc_ready), 32'h1);
endtask

//--- verification/tb_dispatch.sv
`timescale 1ns/1ps

module tb_dispatch;

	// ==================================================
	// Parameters and timing
	// ==================================================
	localparam int ROB_ENTRIES = 8;
	localparam int RS_DEPTH = 4;
	localparam int IDX_BITS = $clog2(ROB_ENTRIES);
	localparam int NSLOT = dispatch_pkg::SLOT_COUNT;
	localparam int RESET_CYCLES = 16;
	localparam logic [15:0] LFSR_SEED = 16'd70;

	// Six tests, each a reset plus at most about 45 cycles of traffic
	localparam int TEST_COUNT = 6;
	localparam int TEST_BUDGET = 60;
	localparam int TIMEOUT_CYCLES = TEST_COUNT * (RESET_CYCLES + 1 + TEST_BUDGET);

	logic clk = 1'b0;
	logic rst_n;

	// Allocation side
	logic alloc_v;
	isa_pkg::instr_word_t alloc_instr;
	dispatch_pkg::preg_t alloc_psrc1;
	dispatch_pkg::preg_t alloc_psrc2;
	dispatch_pkg::preg_t alloc_pdst;
	logic [1:0] alloc_src_ready;
	logic alloc_ready;

	// Wakeup, stomp, commit, credits and configuration
	logic wakeup_v;
	dispatch_pkg::preg_t wakeup_tag;
	logic [ROB_ENTRIES-1:0] stomp_mask;
	logic commit_v;
	logic [NSLOT-1:0] credit_return;
	logic cfg_we;
	logic [NSLOT-1:0] cfg_wdata;
	logic [NSLOT-1:0] cfg_rdata;

	// Issue slots
	logic [NSLOT-1:0] issue_v;
	logic [NSLOT-1:0][IDX_BITS-1:0] issue_rob_idx;
	isa_pkg::opcode_t [NSLOT-1:0] issue_opcode;
	dispatch_pkg::preg_t [NSLOT-1:0] issue_pdst;
	dispatch_pkg::preg_t [NSLOT-1:0] issue_psrc1;
	logic [NSLOT-1:0][dispatch_pkg::OPERAND_BITS-1:0] issue_operand2;
	logic [NSLOT-1:0] issue_is_imm;

	logic [15:0] lfsr_state;
	int cycle_count = 0;

	// 4 ns clock period
	always #2 clk = ~clk;

	dispatch_top #(
		.ROB_ENTRIES(ROB_ENTRIES),
		.RS_DEPTH(RS_DEPTH)
	) uut (
		.clk(clk), .rst_n(rst_n),
		.alloc_v(alloc_v), .alloc_instr(alloc_instr),
		.alloc_psrc1(alloc_psrc1), .alloc_psrc2(alloc_psrc2), .alloc_pdst(alloc_pdst),
		.alloc_src_ready(alloc_src_ready), .alloc_ready(alloc_ready),
		.wakeup_v(wakeup_v), .wakeup_tag(wakeup_tag),
		.stomp_mask(stomp_mask), .commit_v(commit_v),
		.credit_return(credit_return),
		.cfg_we(cfg_we), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.issue_v(issue_v), .issue_rob_idx(issue_rob_idx), .issue_opcode(issue_opcode),
		.issue_pdst(issue_pdst), .issue_psrc1(issue_psrc1),
		.issue_operand2(issue_operand2), .issue_is_imm(issue_is_imm)
	);

	// ==================================================
	// Stimulus source
	// ==================================================
	// Fibonacci LFSR with taps 16, 14, 13 and 11
	// Every bit handed out costs exactly one shift
	function automatic logic [15:0] rand_bits(input int n);
		logic fb;
		logic [15:0] r;
		r = '0;
		for (int b = 0; b < n; b++) begin
			fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic dispatch_pkg::preg_t rand_tag();
		return 7'(rand_bits(7));
	endfunction

	`include "tb_dispatch_tasks.svh"

	// Ends a run that stops making progress
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with tests still running", TIMEOUT_CYCLES);
			$display("Simulation finished: FAIL");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// ==================================================
	// Test sequence
	// ==================================================
	initial begin
		lfsr_state = LFSR_SEED;
		rst_n = 1'b0;
		alloc_v = 1'b0;
		alloc_instr = '0;
		alloc_psrc1 = '0;
		alloc_psrc2 = '0;
		alloc_pdst = '0;
		alloc_src_ready = '0;
		wakeup_v = 1'b0;
		wakeup_tag = '0;
		stomp_mask = '0;
		commit_v = 1'b0;
		credit_return = '0;
		cfg_we = 1'b0;
		cfg_wdata = '0;
		test_reset_state();
		test_single_issue();
		test_wakeup();
		test_class_limits();
		test_credits_config();
		test_stomp_commit();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

//--- sources.f
+incdir+verification
source/isa_pkg.sv
source/dispatch_pkg.sv
source/rob_store.sv
source/instr_dispatcher.sv
source/slot_credit_counter.sv
source/dispatch_config.sv
source/dispatch_top.sv
verification/tb_dispatch.sv

//--- Makefile
# Verilator build for the dispatch subsystem testbench

VERILATOR ?= verilator
TOP ?= tb_dispatch
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --timing --assert
PASS_MSG ?= Simulation finished: PASS

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv) $(wildcard verification/*.sv) $(wildcard verification/*.svh)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the log holds the pass line
sim: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
